// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = memory_backend_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_TEXT = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/memory_backend_tb.sv
`timescale 1ns/1ps

module memory_backend_tb;
	import backend_pkg::*;

	logic      clk;
	logic      reset;
	word_t     alu_result;
	mem_op_t   mem_read;
	mem_op_t   mem_write;
	reg_addr_t rd;
	wb_sel_t   wb;
	reg_addr_t rs1;
	reg_addr_t rs2;
	word_t     rd2;
	word_t     pc_next;
	word_t     curr_pc;
	word_t     branch_offset;
	branch_t   branch_type;
	logic      valid;
	reg_addr_t read_addr_a;
	reg_addr_t read_addr_b;
	logic      branch_dir;
	word_t     branch_dest;
	word_t     read_data_a;
	word_t     read_data_b;

	// Reference memory holds one byte per entry, indexed by address bits 9 to 0.
	logic [7:0] model_mem [1024];
	word_t      model_regs [32];

	logic  check_br;
	logic  check_read;
	logic  exp_dir;
	word_t exp_dest;
	word_t exp_a;
	word_t exp_b;
	int    pass_count;
	int    error_count;
	int    cycle_count;

	memory_backend dut (.*);

	function automatic logic expected_branch(input branch_t bt, input word_t alu);
		case (bt)
			BEQ:       return alu == 32'd0;
			BNE:       return alu != 32'd0;
			BLT, BLTU: return alu[31];
			BGT, BGTU: return !alu[31];
			default:   return 1'b0;
		endcase
	endfunction

	// Offset counts halfwords.
	function automatic word_t expected_dest(input word_t pc, input word_t off);
		return pc + {off[30:0], 1'b0};
	endfunction

	function automatic word_t expected_load(input mem_op_t op, input word_t addr);
		logic [7:0]  b;
		logic [15:0] h;
		word_t       w;
		b = model_mem[addr[9:0]];
		h = {model_mem[{addr[9:1], 1'b1}], model_mem[{addr[9:1], 1'b0}]};
		w = {model_mem[{addr[9:2], 2'd3}], model_mem[{addr[9:2], 2'd2}],
			model_mem[{addr[9:2], 2'd1}], model_mem[{addr[9:2], 2'd0}]};
		case (op)
			LB:      return {{24{b[7]}}, b};
			LH:      return {{16{h[15]}}, h};
			LW:      return w;
			LBU:     return {24'd0, b};
			LHU:     return {16'd0, h};
			default: return '0;
		endcase
	endfunction

	function automatic word_t fill_word(input logic [7:0] w);
		return {w, ~w, w ^ 8'h5a, w + 8'h3c};
	endfunction

	function automatic mem_op_t load_op(input int k);
		case (k)
			0:       return LB;
			1:       return LH;
			2:       return LW;
			3:       return LBU;
			default: return LHU;
		endcase
	endfunction

	// Random upper bits and a lane aligned to the access size.
	function automatic word_t lane_addr(input mem_op_t op, input logic [7:0] w);
		logic [1:0] lane;
		lane = 2'($urandom);
		if (op[1:0] == 2'd1) begin
			lane[0] = 1'b0;
		end else if (op[1:0] == 2'd2) begin
			lane = 2'd0;
		end
		return {22'($urandom), w, lane};
	endfunction

	task automatic store_model(input mem_op_t op, input word_t addr, input word_t data);
		if (op == SB) begin
			model_mem[addr[9:0]] = data[7:0];
		end else if (op == SH) begin
			model_mem[{addr[9:1], 1'b0}] = data[7:0];
			model_mem[{addr[9:1], 1'b1}] = data[15:8];
		end else if (op == SW) begin
			for (int i = 0; i < 4; i++) begin
				model_mem[{addr[9:2], 2'(i)}] = data[8*i +: 8];
			end
		end
	endtask

	task automatic drive_idle();
		valid      <= 1'b0;
		mem_read   <= MEM_NONE;
		mem_write  <= MEM_NONE;
		wb         <= WB_NONE;
		check_br   <= 1'b0;
		check_read <= 1'b0;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		drive_idle();
	endtask

	task automatic issue(input mem_op_t rop, input mem_op_t wop, input reg_addr_t r,
		input wb_sel_t s, input word_t alu, input word_t data, input word_t pcn, input logic v);
		word_t value;
		@(posedge clk);
		drive_idle();
		mem_read   <= rop;
		mem_write  <= wop;
		rd         <= r;
		wb         <= s;
		alu_result <= alu;
		rd2        <= data;
		pc_next    <= pcn;
		valid      <= v;
		case (s)
			WB_ALU:  value = alu;
			WB_MEM:  value = expected_load(rop, alu);
			WB_PC:   value = pcn;
			default: value = '0;
		endcase
		if (v && s != WB_NONE && r != '0) begin
			model_regs[r] = value;
		end
		if (v && wop != MEM_NONE) begin
			store_model(wop, alu, data);
		end
	endtask

	task automatic read_check(input reg_addr_t a);
		@(posedge clk);
		drive_idle();
		read_addr_a <= a;
		read_addr_b <= ~a;
		exp_a       <= model_regs[a];
		exp_b       <= model_regs[~a];
		check_read  <= 1'b1;
	endtask

	task automatic branch_check(input branch_t bt, input word_t alu, input word_t pc,
		input word_t off);
		@(posedge clk);
		drive_idle();
		branch_type   <= bt;
		alu_result    <= alu;
		curr_pc       <= pc;
		branch_offset <= off;
		exp_dir       <= expected_branch(bt, alu);
		exp_dest      <= expected_dest(pc, off);
		check_br      <= 1'b1;
	endtask

	task automatic report_test(input string name, input int err_before);
		@(posedge clk);
		drive_idle();
		$display("%s: done, %0d errors", name, error_count - err_before);
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Outputs are sampled half a cycle after the inputs change.
	always @(negedge clk) begin
		if (check_br) begin
			if (branch_dir !== exp_dir) begin
				$display("ERROR branch_dir: expected %h, actual %h", exp_dir, branch_dir);
				error_count = error_count + 1;
			end else begin
				pass_count = pass_count + 1;
			end
			if (branch_dest !== exp_dest) begin
				$display("ERROR branch_dest: expected %h, actual %h", exp_dest, branch_dest);
				error_count = error_count + 1;
			end else begin
				pass_count = pass_count + 1;
			end
		end
		if (check_read) begin
			if (read_data_a !== exp_a) begin
				$display("ERROR read_data_a (x%0d): expected %h, actual %h",
					read_addr_a, exp_a, read_data_a);
				error_count = error_count + 1;
			end else begin
				pass_count = pass_count + 1;
			end
			if (read_data_b !== exp_b) begin
				$display("ERROR read_data_b (x%0d): expected %h, actual %h",
					read_addr_b, exp_b, read_data_b);
				error_count = error_count + 1;
			end else begin
				pass_count = pass_count + 1;
			end
		end
	end

	// The whole run takes about 1300 cycles.
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count == 3000) begin
			$display("Timeout: the run did not finish within 3000 cycles.");
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		int         err_before;
		word_t      addr;
		mem_op_t    op;
		reg_addr_t  r;
		wb_sel_t    sel;
		logic [7:0] w;
		logic       v;

		void'($urandom(39));
		reset         = 1'b1;
		// A valid register write is held on the inputs for the whole reset.
		alu_result    = 32'hffff_ffff;
		mem_read      = MEM_NONE;
		mem_write     = MEM_NONE;
		rd            = 5'd1;
		wb            = WB_ALU;
		rs1           = '0;
		rs2           = '0;
		rd2           = '0;
		pc_next       = '0;
		curr_pc       = '0;
		branch_offset = '0;
		branch_type   = NO_BRANCH;
		valid         = 1'b1;
		read_addr_a   = '0;
		read_addr_b   = '0;
		check_br      = 1'b0;
		check_read    = 1'b0;
		exp_dir       = 1'b0;
		exp_dest      = '0;
		exp_a         = '0;
		exp_b         = '0;
		pass_count    = 0;
		error_count   = 0;
		cycle_count   = 0;
		model_regs    = '{default: '0};
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		drive_idle();

		err_before = error_count;
		for (int i = 0; i < 32; i++) begin
			read_check(5'(i));
		end
		report_test("reset clears register file", err_before);

		err_before = error_count;
		for (int i = 0; i < 200; i++) begin
			if (i % 4 == 0) begin
				addr = '0;
			end else begin
				addr = $urandom;
			end
			branch_check(3'($urandom), addr, $urandom, $urandom);
		end
		report_test("branch resolution", err_before);

		// Known contents everywhere before partial stores.
		for (int i = 0; i < DMEM_WORDS; i++) begin
			w = 8'(i);
			issue(MEM_NONE, SW, 5'd0, WB_NONE, {22'd0, w, 2'd0}, fill_word(w), '0, 1'b1);
		end
		err_before = error_count;
		for (int i = 0; i < 20; i++) begin
			w  = 8'($urandom);
			op = 3'($urandom % 3);
			issue(MEM_NONE, op, 5'd0, WB_NONE, lane_addr(op, w), $urandom, '0, 1'b1);
			for (int k = 0; k < 5; k++) begin
				r = 5'(1 + $urandom % 31);
				issue(load_op(k), MEM_NONE, r, WB_MEM, lane_addr(load_op(k), w), '0, '0, 1'b1);
				idle_cycle();
				read_check(r);
			end
		end
		report_test("stores and loads", err_before);

		err_before = error_count;
		for (int i = 0; i < 60; i++) begin
			case ($urandom % 3)
				0:       sel = WB_ALU;
				1:       sel = WB_PC;
				default: sel = WB_NONE;
			endcase
			r = (i % 5 == 0) ? 5'd0 : 5'($urandom);
			issue(MEM_NONE, MEM_NONE, r, sel, $urandom, $urandom, $urandom, 1'b1);
			idle_cycle();
			read_check(r);
		end
		report_test("writeback sources", err_before);

		// A small address window makes stores and loads collide often.
		err_before = error_count;
		for (int i = 0; i < 200; i++) begin
			w   = 8'($urandom % 16);
			r   = 5'($urandom);
			v   = ($urandom % 4) != 0;
			sel = ($urandom % 2 == 0) ? WB_ALU : WB_PC;
			case ($urandom % 3)
				0: begin
					op = 3'($urandom % 3);
					issue(MEM_NONE, op, r, WB_NONE, lane_addr(op, w), $urandom, '0, v);
				end
				1: begin
					op = load_op($urandom % 5);
					issue(op, MEM_NONE, r, WB_MEM, lane_addr(op, w), '0, '0, v);
				end
				default: begin
					issue(MEM_NONE, MEM_NONE, r, sel, $urandom, '0, $urandom, v);
				end
			endcase
		end
		idle_cycle();
		idle_cycle();
		for (int i = 0; i < 32; i++) begin
			read_check(5'(i));
		end
		for (int i = 0; i < 16; i++) begin
			issue(LW, MEM_NONE, 5'd1, WB_MEM, {22'd0, 8'(i), 2'd0}, '0, '0, 1'b1);
			idle_cycle();
			read_check(5'd1);
		end
		report_test("valid gating and back-to-back issue", err_before);

		$display("checks passed: %0d, errors: %0d", pass_count, error_count);
		if (error_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: flist.f
logic/backend_pkg.sv
logic/memory_stage.sv
logic/data_memory.sv
logic/mem_wb_register.sv
logic/writeback_stage.sv
logic/memory_backend.sv
bench/memory_backend_tb.sv

// File: logic/backend_pkg.sv
package backend_pkg;

	// Data, address and PC words.
	typedef logic [31:0] word_t;

	// Register file index.
	typedef logic [4:0] reg_addr_t;

	// Load and store operation code.
	typedef logic [2:0] mem_op_t;

	// Writeback source code.
	typedef logic [1:0] wb_sel_t;

	// Conditional branch type.
	typedef logic [2:0] branch_t;

	localparam mem_op_t LB       = 3'd0;
	localparam mem_op_t LH       = 3'd1;
	localparam mem_op_t LW       = 3'd2;
	localparam mem_op_t LBU      = 3'd4;
	localparam mem_op_t LHU      = 3'd5;
	localparam mem_op_t SB       = 3'd0;
	localparam mem_op_t SH       = 3'd1;
	localparam mem_op_t SW       = 3'd2;
	localparam mem_op_t MEM_NONE = 3'd7;

	localparam wb_sel_t WB_NONE = 2'd0;
	localparam wb_sel_t WB_ALU  = 2'd1;
	localparam wb_sel_t WB_MEM  = 2'd2;
	localparam wb_sel_t WB_PC   = 2'd3;

	localparam branch_t NO_BRANCH = 3'd0;
	localparam branch_t BEQ       = 3'd1;
	localparam branch_t BNE       = 3'd2;
	localparam branch_t BLT       = 3'd3;
	localparam branch_t BGT       = 3'd4;
	localparam branch_t BLTU      = 3'd5;
	localparam branch_t BGTU      = 3'd6;

	// Word index comes from address bits 9 to 2.
	localparam int DMEM_INDEX_BITS = 8;
	localparam int DMEM_WORDS      = 2 ** DMEM_INDEX_BITS;

endpackage

// File: logic/data_memory.sv
`timescale 1ns/1ps

module data_memory (
	input  logic                 clk,
	input  backend_pkg::word_t   address,
	input  backend_pkg::word_t   write_data,
	input  backend_pkg::mem_op_t mem_read,
	input  backend_pkg::mem_op_t mem_write,
	input  logic                 valid,
	output backend_pkg::word_t   read_data
);
	import backend_pkg::*;

	word_t mem [DMEM_WORDS];

	logic [DMEM_INDEX_BITS-1:0] index;
	logic [1:0]                 lane;
	logic [3:0]                 byte_en;
	word_t                      store_word;
	word_t                      stored;
	logic [7:0]                 load_byte;
	logic [15:0]                load_half;

	assign index  = address[DMEM_INDEX_BITS+1:2];
	assign lane   = address[1:0];
	assign stored = mem[index];

	// Store data is replicated so each lane sees its own copy.
	always_comb begin
		byte_en    = 4'b0000;
		store_word = write_data;
		if (valid) begin
			case (mem_write)
				SB: begin
					byte_en    = 4'b0001 << lane;
					store_word = {4{write_data[7:0]}};
				end
				SH: begin
					byte_en    = lane[1] ? 4'b1100 : 4'b0011;
					store_word = {2{write_data[15:0]}};
				end
				SW: begin
					byte_en = 4'b1111;
				end
				default: begin
					byte_en = 4'b0000;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (byte_en[i]) begin
				mem[index][8*i +: 8] <= store_word[8*i +: 8];
			end
		end
	end

	assign load_byte = stored[8*lane +: 8];
	assign load_half = lane[1] ? stored[31:16] : stored[15:0];

	always_comb begin
		case (mem_read)
			LB:      read_data = {{24{load_byte[7]}}, load_byte};
			LH:      read_data = {{16{load_half[15]}}, load_half};
			LW:      read_data = stored;
			LBU:     read_data = {24'd0, load_byte};
			LHU:     read_data = {16'd0, load_half};
			default: read_data = '0;
		endcase
	end

endmodule

// File: logic/mem_wb_register.sv
`timescale 1ns/1ps

module mem_wb_register (
	input  logic                   clk,
	input  logic                   reset,
	input  backend_pkg::word_t     alu_result,
	input  backend_pkg::word_t     mem_result,
	input  backend_pkg::word_t     pc_next,
	input  backend_pkg::reg_addr_t rd,
	input  backend_pkg::wb_sel_t   wb,
	input  logic                   valid,

	output backend_pkg::word_t     wb_alu_result,
	output backend_pkg::word_t     wb_mem_result,
	output backend_pkg::word_t     wb_pc_next,
	output backend_pkg::reg_addr_t wb_rd,
	output backend_pkg::wb_sel_t   wb_sel,
	output logic                   wb_valid
);

	// Valid is the only field cleared by reset.
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= valid;
		end
	end

	always_ff @(posedge clk) begin
		wb_alu_result <= alu_result;
		wb_mem_result <= mem_result;
		wb_pc_next    <= pc_next;
		wb_rd         <= rd;
		wb_sel        <= wb;
	end

endmodule

// File: logic/memory_backend.sv
`timescale 1ns/1ps

module memory_backend (
	input  logic                   clk,
	input  logic                   reset,
	input  backend_pkg::word_t     alu_result,
	input  backend_pkg::mem_op_t   mem_read,
	input  backend_pkg::mem_op_t   mem_write,
	input  backend_pkg::reg_addr_t rd,
	input  backend_pkg::wb_sel_t   wb,
	input  backend_pkg::reg_addr_t rs1,
	input  backend_pkg::reg_addr_t rs2,
	input  backend_pkg::word_t     rd2,
	input  backend_pkg::word_t     pc_next,
	input  backend_pkg::word_t     curr_pc,
	input  backend_pkg::word_t     branch_offset,
	input  backend_pkg::branch_t   branch_type,
	input  logic                   valid,
	input  backend_pkg::reg_addr_t read_addr_a,
	input  backend_pkg::reg_addr_t read_addr_b,

	output logic                   branch_dir,
	output backend_pkg::word_t     branch_dest,
	output backend_pkg::word_t     read_data_a,
	output backend_pkg::word_t     read_data_b
);
	import backend_pkg::*;

	word_t     cache_address;
	mem_op_t   cache_mem_read;
	mem_op_t   cache_mem_write;
	word_t     cache_data;
	logic      cache_valid;
	word_t     cache_read_data;

	word_t     stage_alu_result;
	word_t     mem_result;
	reg_addr_t stage_rd;
	wb_sel_t   stage_wb;
	word_t     stage_pc_next;
	logic      stage_valid;

	word_t     wb_alu_result;
	word_t     wb_mem_result;
	word_t     wb_pc_next;
	reg_addr_t wb_rd;
	wb_sel_t   wb_sel;
	logic      wb_valid;

	memory_stage u_memory_stage (
		.alu_result      (alu_result),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.rd              (rd),
		.wb              (wb),
		.rs1             (rs1),
		.rs2             (rs2),
		.rd2             (rd2),
		.pc_next         (pc_next),
		.curr_pc         (curr_pc),
		.branch_offset   (branch_offset),
		.branch_type     (branch_type),
		.valid           (valid),
		.cache_read_data (cache_read_data),
		.cache_address   (cache_address),
		.cache_mem_read  (cache_mem_read),
		.cache_mem_write (cache_mem_write),
		.cache_data      (cache_data),
		.cache_valid     (cache_valid),
		.out_alu_result  (stage_alu_result),
		.mem_result      (mem_result),
		.out_rd          (stage_rd),
		.out_wb          (stage_wb),
		.out_pc_next     (stage_pc_next),
		.out_valid       (stage_valid),
		.branch_dir      (branch_dir),
		.branch_dest     (branch_dest)
	);

	data_memory u_data_memory (
		.clk        (clk),
		.address    (cache_address),
		.write_data (cache_data),
		.mem_read   (cache_mem_read),
		.mem_write  (cache_mem_write),
		.valid      (cache_valid),
		.read_data  (cache_read_data)
	);

	mem_wb_register u_mem_wb_register (
		.clk           (clk),
		.reset         (reset),
		.alu_result    (stage_alu_result),
		.mem_result    (mem_result),
		.pc_next       (stage_pc_next),
		.rd            (stage_rd),
		.wb            (stage_wb),
		.valid         (stage_valid),
		.wb_alu_result (wb_alu_result),
		.wb_mem_result (wb_mem_result),
		.wb_pc_next    (wb_pc_next),
		.wb_rd         (wb_rd),
		.wb_sel        (wb_sel),
		.wb_valid      (wb_valid)
	);

	writeback_stage u_writeback_stage (
		.clk         (clk),
		.reset       (reset),
		.alu_result  (wb_alu_result),
		.mem_result  (wb_mem_result),
		.pc_next     (wb_pc_next),
		.rd          (wb_rd),
		.wb          (wb_sel),
		.valid       (wb_valid),
		.read_addr_a (read_addr_a),
		.read_addr_b (read_addr_b),
		.read_data_a (read_data_a),
		.read_data_b (read_data_b)
	);

endmodule

// File: logic/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
	input  backend_pkg::word_t     alu_result,
	input  backend_pkg::mem_op_t   mem_read,
	input  backend_pkg::mem_op_t   mem_write,
	input  backend_pkg::reg_addr_t rd,
	input  backend_pkg::wb_sel_t   wb,
	input  backend_pkg::reg_addr_t rs1,
	input  backend_pkg::reg_addr_t rs2,
	input  backend_pkg::word_t     rd2,
	input  backend_pkg::word_t     pc_next,
	input  backend_pkg::word_t     curr_pc,
	input  backend_pkg::word_t     branch_offset,
	input  backend_pkg::branch_t   branch_type,
	input  logic                   valid,
	input  backend_pkg::word_t     cache_read_data,

	output backend_pkg::word_t     cache_address,
	output backend_pkg::mem_op_t   cache_mem_read,
	output backend_pkg::mem_op_t   cache_mem_write,
	output backend_pkg::word_t     cache_data,
	output logic                   cache_valid,
	output backend_pkg::word_t     out_alu_result,
	output backend_pkg::word_t     mem_result,
	output backend_pkg::reg_addr_t out_rd,
	output backend_pkg::wb_sel_t   out_wb,
	output backend_pkg::word_t     out_pc_next,
	output logic                   out_valid,
	output logic                   branch_dir,
	output backend_pkg::word_t     branch_dest
);
	import backend_pkg::*;

	// The ALU result is the data address, rd2 the store data.
	assign cache_address   = alu_result;
	assign cache_mem_read  = mem_read;
	assign cache_mem_write = mem_write;
	assign cache_data      = rd2;
	assign cache_valid     = valid;

	assign mem_result     = cache_read_data;
	assign out_alu_result = alu_result;
	assign out_rd         = rd;
	assign out_wb         = wb;
	assign out_pc_next    = pc_next;
	assign out_valid      = valid;

	// Offset is in halfwords.
	assign branch_dest = $signed(curr_pc) + ($signed(branch_offset) <<< 1);

	// Compare already done by the ALU; only sign and zero are looked at here.
	always_comb begin
		case (branch_type)
			BEQ:     branch_dir = (alu_result == '0);
			BNE:     branch_dir = (alu_result != '0);
			BLT:     branch_dir = alu_result[31];
			BGT:     branch_dir = ~alu_result[31];
			BLTU:    branch_dir = alu_result[31];
			BGTU:    branch_dir = ~alu_result[31];
			default: branch_dir = 1'b0;
		endcase
	end

endmodule

// File: logic/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  backend_pkg::word_t     alu_result,
	input  backend_pkg::word_t     mem_result,
	input  backend_pkg::word_t     pc_next,
	input  backend_pkg::reg_addr_t rd,
	input  backend_pkg::wb_sel_t   wb,
	input  logic                   valid,
	input  backend_pkg::reg_addr_t read_addr_a,
	input  backend_pkg::reg_addr_t read_addr_b,
	output backend_pkg::word_t     read_data_a,
	output backend_pkg::word_t     read_data_b
);
	import backend_pkg::*;

	word_t regs [32];
	word_t write_value;
	logic  write_en;

	always_comb begin
		case (wb)
			WB_ALU:  write_value = alu_result;
			WB_MEM:  write_value = mem_result;
			WB_PC:   write_value = pc_next;
			default: write_value = '0;
		endcase
	end

	// x0 is never written.
	assign write_en = valid && (wb != WB_NONE) && (rd != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[rd] <= write_value;
		end
	end

	assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];

endmodule
